// File: common/store_iq_defines.svh
`ifndef STORE_IQ_DEFINES_SVH
`define STORE_IQ_DEFINES_SVH

// ----------------------------------------
// store issue queue sizing
// ----------------------------------------

`define IQ_DEPTH        8   // entries per bank
`define PREG_WIDTH      6   // physical register number
`define ROB_IDX_WIDTH   4   // rob index, wrap bit not counted
`define SQ_IDX_WIDTH    4   // store queue index
`define IMM_WIDTH       12  // store immediate

// writeback broadcast ports seen by every bank
`define WB_PORTS        2

`endif

// File: common/store_iq_pkg.sv
`include "store_iq_defines.svh"

package store_iq_pkg;

    // rob index with direction bit for wrap-around age compare
    typedef struct packed {
        logic                         dir;
        logic [`ROB_IDX_WIDTH-1:0]    idx;
    } rob_idx_t;

    typedef logic [`PREG_WIDTH-1:0]   preg_t;
    typedef logic [`SQ_IDX_WIDTH-1:0] sq_idx_t;
    typedef logic [`IMM_WIDTH-1:0]    imm_t;

    typedef enum logic [1:0] {
        SB = 2'b00,
        SH = 2'b01,
        SW = 2'b10
    } store_op_e;

    // what the address pipe needs to compute and record the store address
    typedef struct packed {
        store_op_e op;
        imm_t      imm;
        rob_idx_t  rob_idx;
        sq_idx_t   sq_idx;
    } addr_payload_t;

    // ----------------------------------------
    // age compare
    // ----------------------------------------

    // a is younger than b
    function automatic logic rob_younger(rob_idx_t a, rob_idx_t b);
        if (a.dir == b.dir) begin
            return a.idx > b.idx;
        end
        return a.idx < b.idx;   // b wrapped past a
    endfunction

endpackage

// File: store_iq/store_dispatch.sv
`timescale 1ns/1ps

`include "store_iq_defines.svh"

module store_dispatch (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  dis_en_i,
    input  logic                  full_i,
    output logic                  alloc_o,
    output store_iq_pkg::sq_idx_t alloc_sq_idx_o,
    output logic                  full_o
);
    import store_iq_pkg::*;

    sq_idx_t sq_cnt_q;   // next store queue index to hand out

    // ----------------------------------------
    // accept / stall
    // ----------------------------------------

    // a dispatch is only taken when both banks have room
    assign alloc_o = dis_en_i & ~full_i;
    assign full_o  = full_i;   // stall back to rename

    assign alloc_sq_idx_o = sq_cnt_q;

    // ----------------------------------------
    // store queue index allocation
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sq_cnt_q <= '0;
        end else if (alloc_o) begin
            sq_cnt_q <= sq_cnt_q + 1'b1;   // wraps with the store queue
        end
    end

    // rename must hold off while either bank reports full
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        dis_en_i |-> !full_i
    ) else $error("store dispatch while issue queue full");

endmodule

// File: store_iq/store_issue_bank.sv
`timescale 1ns/1ps

`include "store_iq_defines.svh"

module store_issue_bank #(
    parameter int PAYLOAD_WIDTH = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     alloc_i,
    input  logic [PAYLOAD_WIDTH-1:0]                 alloc_payload_i,
    input  store_iq_pkg::rob_idx_t                   alloc_rob_idx_i,
    input  store_iq_pkg::preg_t                      alloc_preg_i,
    input  logic                                     alloc_ready_i,
    input  logic [`WB_PORTS-1:0]                     wb_en_i,
    input  store_iq_pkg::preg_t [`WB_PORTS-1:0]      wb_preg_i,
    input  logic                                     redirect_i,
    input  store_iq_pkg::rob_idx_t                   redirect_rob_idx_i,
    output logic                                     full_o,
    output logic                                     sel_valid_o,
    output logic [PAYLOAD_WIDTH-1:0]                 sel_payload_o,
    output store_iq_pkg::preg_t                      sel_preg_o
);
    import store_iq_pkg::*;

    localparam int IDX_W = $clog2(`IQ_DEPTH);

    logic [`IQ_DEPTH-1:0]     valid_q;
    logic [`IQ_DEPTH-1:0]     ready_q;   // source operand available
    preg_t                    preg_q    [`IQ_DEPTH];
    rob_idx_t                 rob_q     [`IQ_DEPTH];
    logic [PAYLOAD_WIDTH-1:0] payload_q [`IQ_DEPTH];

    logic [`IQ_DEPTH-1:0]     wake;
    logic [`IQ_DEPTH-1:0]     flush;
    logic [`IQ_DEPTH-1:0]     ready_vec;
    logic                     alloc_wake;
    logic                     do_alloc;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         sel_idx;

    // ----------------------------------------
    // wakeup and flush match
    // ----------------------------------------

    always_comb begin
        wake       = '0;
        alloc_wake = 1'b0;
        for (int j = 0; j < `WB_PORTS; j++) begin
            if (wb_en_i[j]) begin
                alloc_wake = alloc_wake | (wb_preg_i[j] == alloc_preg_i);   // same-cycle bypass
                for (int i = 0; i < `IQ_DEPTH; i++) begin
                    if (wb_preg_i[j] == preg_q[i]) begin
                        wake[i] = 1'b1;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            flush[i] = valid_q[i] & rob_younger(rob_q[i], redirect_rob_idx_i);
        end
    end

    // ----------------------------------------
    // free slot and select, lowest index wins
    // ----------------------------------------

    assign ready_vec = valid_q & ready_q;

    always_comb begin
        free_idx = '0;
        sel_idx  = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) free_idx = IDX_W'(i);
            if (ready_vec[i]) sel_idx = IDX_W'(i);
        end
    end

    assign full_o        = &valid_q;
    assign do_alloc      = alloc_i & ~redirect_i & ~full_o;
    assign sel_valid_o   = (|ready_vec) & ~redirect_i;   // nothing leaves on redirect
    assign sel_payload_o = payload_q[sel_idx];
    assign sel_preg_o    = preg_q[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            ready_q <= '0;
        end else begin
            ready_q <= ready_q | wake;
            if (redirect_i) begin
                valid_q <= valid_q & ~flush;
            end else begin
                if (sel_valid_o) valid_q[sel_idx] <= 1'b0;
                if (do_alloc) valid_q[free_idx] <= 1'b1;
            end
            if (do_alloc) ready_q[free_idx] <= alloc_ready_i | alloc_wake;
        end
    end

    // entry fields
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            preg_q[free_idx]    <= alloc_preg_i;
            rob_q[free_idx]     <= alloc_rob_idx_i;
            payload_q[free_idx] <= alloc_payload_i;
        end
    end

    a_alloc_not_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        alloc_i |-> !full_o
    ) else $error("allocation into full issue bank");

    // a selected slot was waiting and ready, and is gone one cycle later
    a_sel_ready_freed: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        sel_valid_o |-> (valid_q[sel_idx] && ready_q[sel_idx]) ##1 !valid_q[$past(sel_idx)]
    ) else $error("issue bank selected a slot that was not ready or not freed");

endmodule

// File: store_iq/store_issue_stage.sv
`timescale 1ns/1ps

module store_issue_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        redirect_i,
    input  logic                        addr_sel_i,
    input  store_iq_pkg::addr_payload_t addr_payload_i,
    input  store_iq_pkg::preg_t         addr_preg_i,
    input  logic                        data_sel_i,
    input  store_iq_pkg::sq_idx_t       data_sq_idx_i,
    input  store_iq_pkg::preg_t         data_preg_i,
    output logic                        addr_issue_o,
    output store_iq_pkg::store_op_e     addr_op_o,
    output store_iq_pkg::imm_t          addr_imm_o,
    output store_iq_pkg::rob_idx_t      addr_rob_idx_o,
    output store_iq_pkg::sq_idx_t       addr_sq_idx_o,
    output store_iq_pkg::preg_t         addr_rs1_o,
    output logic                        data_issue_o,
    output store_iq_pkg::sq_idx_t       data_sq_idx_o,
    output store_iq_pkg::preg_t         data_rs2_o
);
    import store_iq_pkg::*;

    // ----------------------------------------
    // issue strobes
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            addr_issue_o <= 1'b0;
            data_issue_o <= 1'b0;
        end else begin
            addr_issue_o <= addr_sel_i & ~redirect_i;   // drop across a redirect
            data_issue_o <= data_sel_i & ~redirect_i;
        end
    end

    // ----------------------------------------
    // issue payload
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (addr_sel_i) begin
            addr_op_o      <= addr_payload_i.op;
            addr_imm_o     <= addr_payload_i.imm;
            addr_rob_idx_o <= addr_payload_i.rob_idx;
            addr_sq_idx_o  <= addr_payload_i.sq_idx;
            addr_rs1_o     <= addr_preg_i;   // base register for the regfile read
        end
        if (data_sel_i) begin
            data_sq_idx_o <= data_sq_idx_i;
            data_rs2_o    <= data_preg_i;
        end
    end

endmodule

// File: hdl/store_issue_queue.sv
`timescale 1ns/1ps

`include "store_iq_defines.svh"

module store_issue_queue (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  logic                               dis_en_i,
    input  store_iq_pkg::store_op_e            dis_op_i,
    input  store_iq_pkg::imm_t                 dis_imm_i,
    input  store_iq_pkg::rob_idx_t             dis_rob_idx_i,
    input  store_iq_pkg::preg_t                dis_rs1_i,
    input  logic                               dis_rs1_ready_i,
    input  store_iq_pkg::preg_t                dis_rs2_i,
    input  logic                               dis_rs2_ready_i,
    input  logic [`WB_PORTS-1:0]               wb_en_i,
    input  store_iq_pkg::preg_t [`WB_PORTS-1:0] wb_preg_i,
    input  logic                               redirect_i,
    input  store_iq_pkg::rob_idx_t             redirect_rob_idx_i,
    output logic                               dis_full_o,
    output logic                               addr_issue_o,
    output store_iq_pkg::store_op_e            addr_op_o,
    output store_iq_pkg::imm_t                 addr_imm_o,
    output store_iq_pkg::rob_idx_t             addr_rob_idx_o,
    output store_iq_pkg::sq_idx_t              addr_sq_idx_o,
    output store_iq_pkg::preg_t                addr_rs1_o,
    output logic                               data_issue_o,
    output store_iq_pkg::sq_idx_t              data_sq_idx_o,
    output store_iq_pkg::preg_t                data_rs2_o
);
    import store_iq_pkg::*;

    logic          alloc;
    sq_idx_t       alloc_sq_idx;
    logic          addr_full;
    logic          data_full;
    addr_payload_t addr_alloc_payload;
    logic          addr_sel;
    addr_payload_t addr_sel_payload;
    preg_t         addr_sel_preg;
    logic          data_sel;
    sq_idx_t       data_sel_sq_idx;
    preg_t         data_sel_preg;

    assign addr_alloc_payload = '{
        op:      dis_op_i,
        imm:     dis_imm_i,
        rob_idx: dis_rob_idx_i,
        sq_idx:  alloc_sq_idx
    };

    store_dispatch u_dispatch (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dis_en_i       (dis_en_i),
        .full_i         (addr_full | data_full),   // either bank stalls dispatch
        .alloc_o        (alloc),
        .alloc_sq_idx_o (alloc_sq_idx),
        .full_o         (dis_full_o)
    );

    // ----------------------------------------
    // address half, waits on rs1
    // ----------------------------------------

    store_issue_bank #(
        .PAYLOAD_WIDTH ($bits(addr_payload_t))
    ) u_addr_bank (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .alloc_i            (alloc),
        .alloc_payload_i    (addr_alloc_payload),
        .alloc_rob_idx_i    (dis_rob_idx_i),
        .alloc_preg_i       (dis_rs1_i),
        .alloc_ready_i      (dis_rs1_ready_i),
        .wb_en_i            (wb_en_i),
        .wb_preg_i          (wb_preg_i),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .full_o             (addr_full),
        .sel_valid_o        (addr_sel),
        .sel_payload_o      (addr_sel_payload),
        .sel_preg_o         (addr_sel_preg)
    );

    // ----------------------------------------
    // data half, waits on rs2
    // ----------------------------------------

    store_issue_bank #(
        .PAYLOAD_WIDTH (`SQ_IDX_WIDTH)
    ) u_data_bank (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .alloc_i            (alloc),
        .alloc_payload_i    (alloc_sq_idx),
        .alloc_rob_idx_i    (dis_rob_idx_i),
        .alloc_preg_i       (dis_rs2_i),
        .alloc_ready_i      (dis_rs2_ready_i),
        .wb_en_i            (wb_en_i),
        .wb_preg_i          (wb_preg_i),
        .redirect_i         (redirect_i),
        .redirect_rob_idx_i (redirect_rob_idx_i),
        .full_o             (data_full),
        .sel_valid_o        (data_sel),
        .sel_payload_o      (data_sel_sq_idx),
        .sel_preg_o         (data_sel_preg)
    );

    store_issue_stage u_issue (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .redirect_i     (redirect_i),
        .addr_sel_i     (addr_sel),
        .addr_payload_i (addr_sel_payload),
        .addr_preg_i    (addr_sel_preg),
        .data_sel_i     (data_sel),
        .data_sq_idx_i  (data_sel_sq_idx),
        .data_preg_i    (data_sel_preg),
        .addr_issue_o   (addr_issue_o),
        .addr_op_o      (addr_op_o),
        .addr_imm_o     (addr_imm_o),
        .addr_rob_idx_o (addr_rob_idx_o),
        .addr_sq_idx_o  (addr_sq_idx_o),
        .addr_rs1_o     (addr_rs1_o),
        .data_issue_o   (data_issue_o),
        .data_sq_idx_o  (data_sq_idx_o),
        .data_rs2_o     (data_rs2_o)
    );

endmodule

// File: dv/tb_store_issue_queue.sv
`timescale 1ns/1ps

`include "store_iq_defines.svh"

module tb_store_issue_queue;
    import store_iq_pkg::*;

    localparam int N_DISPATCH = 37;   // 20 + 4 + 9 + 4 stores
    localparam int MAX_CYCLES = N_DISPATCH * 20 + 200;

    logic                      clk;
    logic                      rst_n;
    logic                      dis_en;
    store_op_e                 dis_op;
    imm_t                      dis_imm;
    rob_idx_t                  dis_rob_idx;
    preg_t                     dis_rs1;
    logic                      dis_rs1_ready;
    preg_t                     dis_rs2;
    logic                      dis_rs2_ready;
    logic [`WB_PORTS-1:0]      wb_en;
    preg_t [`WB_PORTS-1:0]     wb_preg;
    logic                      redirect;
    rob_idx_t                  redirect_rob_idx;
    logic                      dis_full;
    logic                      addr_issue;
    store_op_e                 addr_op;
    imm_t                      addr_imm;
    rob_idx_t                  addr_rob_idx;
    sq_idx_t                   addr_sq_idx;
    preg_t                     addr_rs1;
    logic                      data_issue;
    sq_idx_t                   data_sq_idx;
    preg_t                     data_rs2;

    store_issue_queue dut (
        .clk (clk), .rst_n_i (rst_n),
        .dis_en_i (dis_en), .dis_op_i (dis_op), .dis_imm_i (dis_imm),
        .dis_rob_idx_i (dis_rob_idx), .dis_rs1_i (dis_rs1), .dis_rs1_ready_i (dis_rs1_ready),
        .dis_rs2_i (dis_rs2), .dis_rs2_ready_i (dis_rs2_ready),
        .wb_en_i (wb_en), .wb_preg_i (wb_preg),
        .redirect_i (redirect), .redirect_rob_idx_i (redirect_rob_idx),
        .dis_full_o (dis_full),
        .addr_issue_o (addr_issue), .addr_op_o (addr_op), .addr_imm_o (addr_imm),
        .addr_rob_idx_o (addr_rob_idx), .addr_sq_idx_o (addr_sq_idx), .addr_rs1_o (addr_rs1),
        .data_issue_o (data_issue), .data_sq_idx_o (data_sq_idx), .data_rs2_o (data_rs2)
    );

    // ----------------------------------------
    // reference model, keyed by sq index
    // ----------------------------------------

    logic       a_pend [16];
    logic       d_pend [16];
    logic       a_rdy  [16];
    logic       d_rdy  [16];
    logic [1:0] m_op   [16];
    imm_t       m_imm  [16];
    logic [4:0] m_rob  [16];
    preg_t      m_rs1  [16];
    preg_t      m_rs2  [16];

    logic [31:0] rng = 32'hffc7;
    logic [3:0]  sq_cnt;
    logic [4:0]  rob_cnt;
    logic [5:0]  wait_reg;   // waiting sources use regs 32..63
    int          errors;
    int          cycles;
    logic        redir_q;
    string       test_name;

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // a younger than b, direction bit decides across the wrap
    function automatic logic is_younger(logic [4:0] a, logic [4:0] b);
        if (a[4] == b[4]) return a[3:0] > b[3:0];
        return a[3:0] < b[3:0];
    endfunction

    // expected address issue: op, imm, rob, rs1
    function automatic logic [24:0] exp_addr(logic [3:0] k);
        return {m_op[k], m_imm[k], m_rob[k], m_rs1[k]};
    endfunction

    function automatic int addr_waiting();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) if (a_pend[i]) n++;
        return n;
    endfunction

    function automatic int all_waiting();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) if (a_pend[i] || d_pend[i]) n++;
        return n;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------
    // compare issued records
    // ----------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            redir_q = 1'b0;
        end else begin
            if (redir_q) assert (!addr_issue && !data_issue) else begin
                errors++;
                $display("issue strobe seen in the cycle after a redirect");
            end
            redir_q = redirect;
            if (addr_issue) begin
                assert (a_pend[addr_sq_idx] && a_rdy[addr_sq_idx]) else begin
                    errors++;
                    $display("%s: address issue for sq %0d matches no waiting ready store",
                             test_name, addr_sq_idx);
                end
                assert ({addr_op, addr_imm, addr_rob_idx, addr_rs1} == exp_addr(addr_sq_idx))
                else begin
                    errors++;
                    $display("Error %s: expected %h, actual %h", test_name,
                             exp_addr(addr_sq_idx), {addr_op, addr_imm, addr_rob_idx, addr_rs1});
                end
                a_pend[addr_sq_idx] = 1'b0;
            end
            if (data_issue) begin
                assert (d_pend[data_sq_idx] && d_rdy[data_sq_idx]) else begin
                    errors++;
                    $display("%s: data issue for sq %0d matches no waiting ready store",
                             test_name, data_sq_idx);
                end
                assert (data_rs2 == m_rs2[data_sq_idx]) else begin
                    errors++;
                    $display("Error %s: expected %h, actual %h", test_name,
                             m_rs2[data_sq_idx], data_rs2);
                end
                d_pend[data_sq_idx] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, issue queue stopped making progress", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------

    task automatic clear_strobes();
        dis_en   = 1'b0;
        wb_en    = '0;
        redirect = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            clear_strobes();
        end
    endtask

    task automatic dispatch_store(logic r1_rdy, logic r2_rdy);
        logic [31:0] r;
        logic [1:0]  op;
        preg_t       rs1;
        preg_t       rs2;
        r   = rand32();
        op  = 2'(r % 3);
        rs1 = r1_rdy ? {1'b0, r[8:4]} : wait_reg;
        if (!r1_rdy) wait_reg = wait_reg + 6'd1;
        rs2 = r2_rdy ? {1'b0, r[13:9]} : wait_reg;
        if (!r2_rdy) wait_reg = wait_reg + 6'd1;
        if (wait_reg < 6'd32) wait_reg = 6'd32;
        @(negedge clk);
        clear_strobes();
        while (dis_full) @(negedge clk);
        dis_en        = 1'b1;
        dis_op        = store_op_e'(op);
        dis_imm       = r[31:20];
        dis_rob_idx   = rob_cnt;
        dis_rs1       = rs1;
        dis_rs1_ready = r1_rdy;
        dis_rs2       = rs2;
        dis_rs2_ready = r2_rdy;
        a_pend[sq_cnt] = 1'b1;
        d_pend[sq_cnt] = 1'b1;
        a_rdy[sq_cnt]  = r1_rdy;
        d_rdy[sq_cnt]  = r2_rdy;
        m_op[sq_cnt]   = op;
        m_imm[sq_cnt]  = r[31:20];
        m_rob[sq_cnt]  = rob_cnt;
        m_rs1[sq_cnt]  = rs1;
        m_rs2[sq_cnt]  = rs2;
        sq_cnt  = sq_cnt + 4'd1;   // wraps like the store queue
        rob_cnt = rob_cnt + 5'd1;
    endtask

    task automatic writeback(int port, preg_t p);
        @(negedge clk);
        clear_strobes();
        wb_en[port]   = 1'b1;
        wb_preg[port] = p;
        for (int i = 0; i < 16; i++) begin
            if (a_pend[i] && m_rs1[i] == p) a_rdy[i] = 1'b1;
            if (d_pend[i] && m_rs2[i] == p) d_rdy[i] = 1'b1;
        end
    endtask

    task automatic wake_all();
        for (int i = 0; i < 16; i++) begin
            if (a_pend[i] && !a_rdy[i]) writeback(i % 2, m_rs1[i]);
            if (d_pend[i] && !d_rdy[i]) writeback((i + 1) % 2, m_rs2[i]);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle(1);
        while (all_waiting() != 0 && n < 60) begin
            idle(1);
            n++;
        end
        idle(3);
        for (int i = 0; i < 16; i++) begin
            if (a_pend[i] || d_pend[i]) begin
                errors++;
                $display("%s: store with sq %0d was never issued", test_name, i);
                a_pend[i] = 1'b0;
                d_pend[i] = 1'b0;
            end
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------

    initial begin
        logic [4:0] ridx;
        errors = 0;
        cycles = 0;
        sq_cnt = '0;
        rob_cnt = '0;
        wait_reg = 6'd32;
        test_name = "reset";
        for (int i = 0; i < 16; i++) begin
            a_pend[i] = 1'b0;
            d_pend[i] = 1'b0;
        end
        rst_n = 1'b0;
        clear_strobes();
        dis_op = SB;
        dis_imm = '0;
        dis_rob_idx = '0;
        dis_rs1 = '0;
        dis_rs1_ready = 1'b0;
        dis_rs2 = '0;
        dis_rs2_ready = 1'b0;
        wb_preg = '0;
        redirect_rob_idx = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (!dis_full && !addr_issue && !data_issue) else begin
            errors++;
            $display("outputs not idle after reset");
        end

        test_name = "ready_wrap";   // 20 stores run the sq index past 16
        repeat (20) dispatch_store(1'b1, 1'b1);
        drain();

        test_name = "wakeup";
        repeat (4) begin
            logic [31:0] r;
            r = rand32();
            dispatch_store(r[0], r[1]);
        end
        idle(5);
        wake_all();
        drain();

        test_name = "full";
        repeat (8) dispatch_store(1'b0, 1'b0);
        idle(1);
        assert (dis_full == (addr_waiting() >= `IQ_DEPTH)) else begin
            errors++;
            $display("Error %s: expected %b, actual %b", test_name,
                     addr_waiting() >= `IQ_DEPTH, dis_full);
        end
        writeback(0, m_rs1[sq_cnt - 4'd8]);
        writeback(1, m_rs2[sq_cnt - 4'd8]);
        dispatch_store(1'b0, 1'b0);   // accepted only once full falls
        wake_all();
        drain();

        test_name = "redirect";   // rob 14, 15, then across the wrap
        rob_cnt = 5'b01110;
        repeat (4) dispatch_store(1'b0, 1'b0);
        idle(3);
        writeback(0, m_rs1[sq_cnt - 4'd4]);   // oldest base is ready as the redirect hits
        ridx = 5'b01111;
        @(negedge clk);
        clear_strobes();
        redirect = 1'b1;
        redirect_rob_idx = ridx;
        for (int i = 0; i < 16; i++) begin
            if (is_younger(m_rob[i], ridx)) begin
                a_pend[i] = 1'b0;
                d_pend[i] = 1'b0;
            end
        end
        idle(2);
        // flushed halves get their sources too, a kept one would then issue
        for (int k = 4; k > 0; k--) begin
            writeback(0, m_rs1[sq_cnt - 4'(k)]);
            writeback(1, m_rs2[sq_cnt - 4'(k)]);
        end
        drain();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/store_iq_pkg.sv
store_iq/store_dispatch.sv
store_iq/store_issue_bank.sv
store_iq/store_issue_stage.sv
hdl/store_issue_queue.sv
dv/tb_store_issue_queue.sv

// File: Makefile
TOP = tb_store_issue_queue

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): files.f common/*.sv common/*.svh store_iq/*.sv hdl/*.sv dv/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
